//--- hdl/epu_geom_pkg.sv
package epu_geom_pkg;

    // Macroblock edge in luma pixels
    localparam int MB_SIZE = 16;

    // Four pixels per 32-bit word, so 16 rows of 4 words
    localparam int WORDS_PER_MB = 64;

    // Depth of the line buffer that holds the row above
    localparam int MAX_MB_COLS = 64;

    localparam int MB_IDX_W = 6;
    localparam int DIM_W    = 12;  // Frame width and height inputs

    // Word address, enough for a 1 Mpixel luma plane
    localparam int WB_ADR_W = 18;

    typedef logic [7:0] pixel_t;

    typedef logic [MB_IDX_W-1:0] mb_idx_t;

endpackage : epu_geom_pkg

//--- hdl/intra_pkg.sv
package intra_pkg;

    // Mode numbers as in the H.264 Intra16x16 prediction mode
    typedef enum logic [1:0] {
        MODE_VERT = 2'd0,
        MODE_HORZ = 2'd1,
        MODE_DC   = 2'd2
    } intra16_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECIDE,
        ST_REPORT,
        ST_COMMIT
    } ctrl_state_t;

    // Worst case is 256 pixels with a difference of 255 each
    localparam int SAD_W = 16;

    typedef logic [SAD_W-1:0] sad_t;

endpackage : intra_pkg

//--- hdl/luma_word_if.sv
`timescale 1ns/100ps

interface luma_word_if;

    logic        start;       // Begins one macroblock fetch
    logic [31:0] word_data;
    logic        word_valid;
    logic        mb_full;     // Last word of the macroblock is being stored

    modport ctrl (
        output start,
        input  mb_full
    );

    modport reader (
        input  start,
        output word_data,
        output word_valid
    );

    modport fetch (
        input  start,
        input  word_data,
        input  word_valid,
        output mb_full
    );

endinterface : luma_word_if

//--- hdl/epu_ctrl.sv
`timescale 1ns/100ps

module epu_ctrl
    import epu_geom_pkg::*, intra_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [DIM_W-1:0] frame_width_i,
    input  logic [DIM_W-1:0] frame_height_i,
    input  logic             start_i,
    input  logic             res_ready_i,
    luma_word_if.ctrl        lw,
    input  logic             decide_done_i,
    output logic             decide_start_o,
    output logic             commit_o,
    output mb_idx_t          mb_x_o,
    output mb_idx_t          mb_y_o,
    output logic             res_valid_o,
    output logic             busy_o,
    output logic             done_o
);

    ctrl_state_t      state;
    ctrl_state_t      state_nxt;
    logic [DIM_W-1:0] mb_cols;
    logic [DIM_W-1:0] mb_rows;
    logic             last_col;
    logic             last_row;
    logic             last_mb;

    assign mb_cols  = frame_width_i / DIM_W'(MB_SIZE);
    assign mb_rows  = frame_height_i / DIM_W'(MB_SIZE);
    assign last_col = (DIM_W'(mb_x_o) == mb_cols - DIM_W'(1));
    assign last_row = (DIM_W'(mb_y_o) == mb_rows - DIM_W'(1));
    assign last_mb  = last_col && last_row;

    assign res_valid_o = (state == ST_REPORT);  // Fields are held by their sources here
    assign commit_o    = (state == ST_COMMIT);
    assign busy_o      = (state != ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (start_i) state_nxt = ST_FETCH;
            ST_FETCH:  if (lw.mb_full) state_nxt = ST_DECIDE;
            ST_DECIDE: if (decide_done_i) state_nxt = ST_REPORT;
            ST_REPORT: if (res_ready_i) state_nxt = ST_COMMIT;
            ST_COMMIT: state_nxt = last_mb ? ST_IDLE : ST_FETCH;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            lw.start       <= 1'b0;
            decide_start_o <= 1'b0;
            done_o         <= 1'b0;
        end else begin
            state          <= state_nxt;
            // Start pulse lands in the first cycle of every fetch
            lw.start       <= (state_nxt == ST_FETCH) && (state != ST_FETCH);
            decide_start_o <= (state == ST_FETCH) && lw.mb_full;
            done_o         <= (state == ST_COMMIT) && last_mb;
        end
    end

    // Raster position, restarted by every new frame
    always_ff @(posedge clk) begin
        if (rst) begin
            mb_x_o <= '0;
            mb_y_o <= '0;
        end else if (state == ST_IDLE && start_i) begin
            mb_x_o <= '0;
            mb_y_o <= '0;
        end else if (state == ST_COMMIT && !last_mb) begin
            if (last_col) begin
                mb_x_o <= '0;
                mb_y_o <= mb_y_o + 1'b1;
            end else begin
                mb_x_o <= mb_x_o + 1'b1;
            end
        end
    end

endmodule : epu_ctrl

//--- hdl/wb_frame_reader.sv
`timescale 1ns/100ps

module wb_frame_reader
    import epu_geom_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DIM_W-1:0]    frame_width_i,
    input  mb_idx_t             mb_x_i,
    input  mb_idx_t             mb_y_i,
    luma_word_if.reader         lw,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    input  logic [31:0]         wb_dat_i,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    input  logic                wb_ack_i
);

    logic                            busy;
    logic [$clog2(WORDS_PER_MB)-1:0] word_cnt;
    logic [DIM_W-1:0]                pix_row;
    logic [WB_ADR_W+1:0]             byte_adr;

    // Word k is row k/4, columns 4*(k mod 4) onward
    assign pix_row  = DIM_W'(mb_y_i) * DIM_W'(MB_SIZE) + DIM_W'(word_cnt[5:2]);
    assign byte_adr = (WB_ADR_W+2)'(pix_row) * (WB_ADR_W+2)'(frame_width_i)
                    + (WB_ADR_W+2)'(mb_x_i) * (WB_ADR_W+2)'(MB_SIZE)
                    + (WB_ADR_W+2)'({word_cnt[1:0], 2'b00});
    assign wb_adr_o = byte_adr[WB_ADR_W+1:2];  // Stable while stb is high

    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= 1'b0;
            word_cnt      <= '0;
            wb_cyc_o      <= 1'b0;
            wb_stb_o      <= 1'b0;
            lw.word_valid <= 1'b0;
        end else begin
            lw.word_valid <= 1'b0;
            if (lw.start) begin
                busy     <= 1'b1;
                word_cnt <= '0;
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
            end else if (wb_stb_o && wb_ack_i) begin
                // Drop the strobe for one idle cycle between reads
                wb_cyc_o      <= 1'b0;
                wb_stb_o      <= 1'b0;
                lw.word_valid <= 1'b1;
                word_cnt      <= word_cnt + 1'b1;
                if (word_cnt == 6'(WORDS_PER_MB - 1))
                    busy <= 1'b0;
            end else if (busy && !wb_stb_o) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_stb_o && wb_ack_i)
            lw.word_data <= wb_dat_i;
    end

endmodule : wb_frame_reader

//--- hdl/luma_fetch.sv
`timescale 1ns/100ps

module luma_fetch
    import epu_geom_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    luma_word_if.fetch lw,
    output pixel_t    mb_o [MB_SIZE][MB_SIZE]
);

    logic [3:0] pos_x;  // Leftmost column of the current word
    logic [3:0] pos_y;
    logic       last_word;

    assign last_word = (pos_y == 4'(MB_SIZE - 1)) && (pos_x == 4'(MB_SIZE - 4));
    assign lw.mb_full = lw.word_valid && last_word;

    always_ff @(posedge clk) begin
        if (rst || lw.start) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (lw.word_valid) begin
            pos_x <= pos_x + 4'd4;  // Wraps to 0 after the fourth word of a row
            if (pos_x == 4'(MB_SIZE - 4))
                pos_y <= pos_y + 4'd1;
        end
    end

    // Lowest byte of the word is the leftmost pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MB_SIZE; i++) begin
                for (int j = 0; j < MB_SIZE; j++)
                    mb_o[i][j] <= '0;
            end
        end else if (lw.word_valid) begin
            for (int b = 0; b < 4; b++)
                mb_o[pos_y][pos_x + 4'(b)] <= lw.word_data[8*b +: 8];
        end
    end

endmodule : luma_fetch

//--- hdl/neighbor_store.sv
`timescale 1ns/100ps

module neighbor_store
    import epu_geom_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    commit_i,
    input  mb_idx_t mb_x_i,
    input  pixel_t  mb_i [MB_SIZE][MB_SIZE],
    output pixel_t  top_row_o [MB_SIZE],
    output pixel_t  left_col_o [MB_SIZE]
);

    // Bottom row of the last macroblock committed in each column
    pixel_t line_buf [MAX_MB_COLS][MB_SIZE];
    pixel_t left_q [MB_SIZE];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < MAX_MB_COLS; c++) begin
                for (int j = 0; j < MB_SIZE; j++)
                    line_buf[c][j] <= '0;
            end
        end else if (commit_i) begin
            for (int j = 0; j < MB_SIZE; j++)
                line_buf[mb_x_i][j] <= mb_i[MB_SIZE-1][j];
        end
    end

    // Rightmost column becomes the left neighbour of the next macroblock
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < MB_SIZE; j++)
                left_q[j] <= '0;
        end else if (commit_i) begin
            for (int j = 0; j < MB_SIZE; j++)
                left_q[j] <= mb_i[j][MB_SIZE-1];
        end
    end

    always_comb begin
        for (int j = 0; j < MB_SIZE; j++) begin
            top_row_o[j]  = line_buf[mb_x_i][j];
            left_col_o[j] = left_q[j];
        end
    end

endmodule : neighbor_store

//--- hdl/intra16_decide.sv
`timescale 1ns/100ps

module intra16_decide
    import epu_geom_pkg::*, intra_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start_i,
    input  mb_idx_t       mb_x_i,
    input  mb_idx_t       mb_y_i,
    input  pixel_t        mb_i [MB_SIZE][MB_SIZE],
    input  pixel_t        top_row_i [MB_SIZE],
    input  pixel_t        left_col_i [MB_SIZE],
    output logic          done_o,
    output intra16_mode_t mode_o,
    output sad_t          sad_o
);

    logic [4:0]    phase;  // 1 is the DC cycle, 2 to 17 the rows, 18 the pick
    logic          top_av;
    logic          left_av;
    logic [12:0]   sum_top;
    logic [12:0]   sum_left;
    logic [12:0]   sum_both;
    pixel_t        dc_val;
    pixel_t        dc_q;
    logic [3:0]    row;
    sad_t          row_v;
    sad_t          row_h;
    sad_t          row_dc;
    sad_t          acc_v;
    sad_t          acc_h;
    sad_t          acc_dc;
    intra16_mode_t best_mode;
    sad_t          best_sad;

    function automatic pixel_t abs_diff(pixel_t a, pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign top_av  = (mb_y_i != '0);
    assign left_av = (mb_x_i != '0);
    assign row     = 4'(phase - 5'd2);
    assign done_o  = (phase == 5'(MB_SIZE + 2));

    always_comb begin
        sum_top  = '0;
        sum_left = '0;
        for (int j = 0; j < MB_SIZE; j++) begin
            sum_top  = sum_top + 13'(top_row_i[j]);
            sum_left = sum_left + 13'(left_col_i[j]);
        end
        sum_both = sum_top + sum_left + 13'd16;
        if (top_av && left_av)
            dc_val = pixel_t'(sum_both >> 5);
        else if (top_av)
            dc_val = pixel_t'((sum_top + 13'd8) >> 4);
        else if (left_av)
            dc_val = pixel_t'((sum_left + 13'd8) >> 4);
        else
            dc_val = 8'd128;  // No neighbours, mid grey
    end

    always_comb begin
        row_v  = '0;
        row_h  = '0;
        row_dc = '0;
        for (int j = 0; j < MB_SIZE; j++) begin
            row_v  = row_v + sad_t'(abs_diff(mb_i[row][j], top_row_i[j]));
            row_h  = row_h + sad_t'(abs_diff(mb_i[row][j], left_col_i[row]));
            row_dc = row_dc + sad_t'(abs_diff(mb_i[row][j], dc_q));
        end
    end

    // Order of the checks gives ties to the lower mode number
    always_comb begin
        best_mode = MODE_DC;
        best_sad  = acc_dc;
        if (left_av && acc_h <= best_sad) begin
            best_mode = MODE_HORZ;
            best_sad  = acc_h;
        end
        if (top_av && acc_v <= best_sad) begin
            best_mode = MODE_VERT;
            best_sad  = acc_v;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            phase <= '0;
        else if (start_i)
            phase <= 5'd1;
        else if (done_o)
            phase <= '0;
        else if (phase != '0)
            phase <= phase + 5'd1;
    end

    always_ff @(posedge clk) begin
        if (phase == 5'd1) begin
            dc_q   <= dc_val;
            acc_v  <= '0;
            acc_h  <= '0;
            acc_dc <= '0;
        end else if (phase >= 5'd2 && phase <= 5'(MB_SIZE + 1)) begin
            acc_v  <= acc_v + row_v;
            acc_h  <= acc_h + row_h;
            acc_dc <= acc_dc + row_dc;
        end
        if (done_o) begin
            mode_o <= best_mode;
            sad_o  <= best_sad;
        end
    end

endmodule : intra16_decide

//--- hdl/h264_intra_top.sv
`timescale 1ns/100ps

module h264_intra_top
    import epu_geom_pkg::*, intra_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DIM_W-1:0]    frame_width_i,
    input  logic [DIM_W-1:0]    frame_height_i,
    input  logic                start_i,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    input  logic [31:0]         wb_dat_i,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    input  logic                wb_ack_i,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output mb_idx_t             res_mb_x_o,
    output mb_idx_t             res_mb_y_o,
    output intra16_mode_t       res_mode_o,
    output sad_t                res_sad_o,
    output logic                busy_o,
    output logic                done_o
);

    logic   decide_start;
    logic   decide_done;
    logic   commit;
    pixel_t mb [MB_SIZE][MB_SIZE];
    pixel_t top_row [MB_SIZE];
    pixel_t left_col [MB_SIZE];

    luma_word_if lw ();

    // The result position doubles as the position of the macroblock in flight
    epu_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .frame_width_i  (frame_width_i),
        .frame_height_i (frame_height_i),
        .start_i        (start_i),
        .res_ready_i    (res_ready_i),
        .lw             (lw.ctrl),
        .decide_done_i  (decide_done),
        .decide_start_o (decide_start),
        .commit_o       (commit),
        .mb_x_o         (res_mb_x_o),
        .mb_y_o         (res_mb_y_o),
        .res_valid_o    (res_valid_o),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    wb_frame_reader u_reader (
        .clk           (clk),
        .rst           (rst),
        .frame_width_i (frame_width_i),
        .mb_x_i        (res_mb_x_o),
        .mb_y_i        (res_mb_y_o),
        .lw            (lw.reader),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_ack_i      (wb_ack_i)
    );

    luma_fetch u_fetch (
        .clk  (clk),
        .rst  (rst),
        .lw   (lw.fetch),
        .mb_o (mb)
    );

    neighbor_store u_nbr (
        .clk        (clk),
        .rst        (rst),
        .commit_i   (commit),
        .mb_x_i     (res_mb_x_o),
        .mb_i       (mb),
        .top_row_o  (top_row),
        .left_col_o (left_col)
    );

    intra16_decide u_decide (
        .clk        (clk),
        .rst        (rst),
        .start_i    (decide_start),
        .mb_x_i     (res_mb_x_o),
        .mb_y_i     (res_mb_y_o),
        .mb_i       (mb),
        .top_row_i  (top_row),
        .left_col_i (left_col),
        .done_o     (decide_done),
        .mode_o     (res_mode_o),
        .sad_o      (res_sad_o)
    );

endmodule : h264_intra_top

//--- test/h264_intra_asserts.sv
`timescale 1ns/100ps

module h264_intra_asserts
    import epu_geom_pkg::*, intra_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic [WB_ADR_W-1:0] wb_adr_o,
    input logic                wb_cyc_o,
    input logic                wb_stb_o,
    input logic                wb_ack_i,
    input logic                res_valid_o,
    input logic                res_ready_i,
    input mb_idx_t             res_mb_x_o,
    input mb_idx_t             res_mb_y_o,
    input intra16_mode_t       res_mode_o,
    input sad_t                res_sad_o
);

    int unsigned assert_fails;  // Read by the testbench at the end of the run

    initial assert_fails = 0;

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o)
        else begin
            assert_fails++;
            $error("Wishbone stb is high without cyc");
        end

    // A request waiting for its ack keeps the same address
    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
        else begin
            assert_fails++;
            $error("Wishbone address changed before ack");
        end

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_mb_x_o)
            && $stable(res_mb_y_o) && $stable(res_mode_o) && $stable(res_sad_o)))
        else begin
            assert_fails++;
            $error("Result changed or dropped while not accepted");
        end

    a_rst_valid: assert property (@(posedge clk) rst |=> !res_valid_o)
        else begin
            assert_fails++;
            $error("res_valid_o high in the cycle after reset");
        end

endmodule : h264_intra_asserts

bind h264_intra_top h264_intra_asserts u_asserts (.*);

//--- test/tb_h264_intra.sv
`timescale 1ns/100ps

module tb_h264_intra
    import epu_geom_pkg::*, intra_pkg::*;
();

    localparam int PAT_FLAT    = 0;
    localparam int PAT_VSTRIPE = 1;
    localparam int PAT_HSTRIPE = 2;
    localparam int PAT_RANDOM  = 3;
    localparam int N_ROWS      = 8;
    localparam int TIMEOUT_CYC = 2000;

    typedef struct packed {
        int test_no;
        int width;
        int height;
        int pattern;
        int stall;  // Cycles with res_ready_i low before each result is taken
    } frame_cfg_t;

    logic                clk;
    logic                rst;
    logic [DIM_W-1:0]    frame_width_i;
    logic [DIM_W-1:0]    frame_height_i;
    logic                start_i;
    logic [WB_ADR_W-1:0] wb_adr_o;
    logic [31:0]         wb_dat_i;
    logic                wb_cyc_o;
    logic                wb_stb_o;
    logic                wb_ack_i;
    logic                res_valid_o;
    logic                res_ready_i;
    mb_idx_t             res_mb_x_o;
    mb_idx_t             res_mb_y_o;
    intra16_mode_t       res_mode_o;
    sad_t                res_sad_o;
    logic                busy_o;
    logic                done_o;

    frame_cfg_t frames [N_ROWS];
    logic [7:0] pix [4096];  // Raster luma frame, one byte per pixel
    int         ack_wait;
    int         checks;
    int         errors;
    int         tests;
    bit         timed_out;

    h264_intra_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Wishbone slave with a random ack delay
    initial begin
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        ack_wait = -1;
        forever begin
            @(posedge clk);
            #2;
            wb_ack_i = 1'b0;
            if (wb_cyc_o === 1'b1 && wb_stb_o === 1'b1) begin
                if (ack_wait < 0)
                    ack_wait = $urandom % 4;
                if (ack_wait == 0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = mem_word(wb_adr_o);
                    ack_wait = -1;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    function automatic logic [31:0] mem_word(logic [WB_ADR_W-1:0] adr);
        int b;
        b = 4 * int'(adr);
        return {pix[b+3], pix[b+2], pix[b+1], pix[b]};  // Leftmost pixel in the low byte
    endfunction

    function automatic int abs_int(int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic string pattern_name(int p);
        case (p)
            PAT_FLAT:    return "flat";
            PAT_VSTRIPE: return "vertical stripes";
            PAT_HSTRIPE: return "horizontal stripes";
            default:     return "random";
        endcase
    endfunction

    task automatic fill_frame(input int pat, input int w, input int h);
        for (int a = 0; a < 4096; a++) begin
            if (a >= w * h)
                pix[a] = 8'h00;
            else if (pat == PAT_FLAT)
                pix[a] = 8'd77;
            else if (pat == PAT_VSTRIPE)
                pix[a] = 8'((a % w) * 7 + 3);
            else if (pat == PAT_HSTRIPE)
                pix[a] = 8'((a / w) * 5 + 10);
            else
                pix[a] = 8'($urandom);
        end
    endtask

    // Mode choice on original pixels; the first mode with the lowest SAD wins
    task automatic expect_mb(input int w, input int mx, input int my,
                             output int mode, output int sad);
        int x0;
        int y0;
        int sum;
        int dc;
        int p;
        int sv;
        int sh;
        int sd;
        bit top_av;
        bit left_av;
        x0 = mx * MB_SIZE;
        y0 = my * MB_SIZE;
        top_av = (my != 0);
        left_av = (mx != 0);
        sum = 0;
        for (int j = 0; j < MB_SIZE; j++) begin
            if (top_av)
                sum += pix[(y0 - 1) * w + x0 + j];
            if (left_av)
                sum += pix[(y0 + j) * w + x0 - 1];
        end
        if (top_av && left_av)
            dc = (sum + 16) / 32;
        else if (top_av || left_av)
            dc = (sum + 8) / 16;
        else
            dc = 128;
        sv = 0;
        sh = 0;
        sd = 0;
        for (int i = 0; i < MB_SIZE; i++) begin
            for (int j = 0; j < MB_SIZE; j++) begin
                p = pix[(y0 + i) * w + x0 + j];
                sv += abs_int(p - int'(pix[(y0 - 1) * w + x0 + j]));
                sh += abs_int(p - int'(pix[(y0 + i) * w + x0 - 1]));
                sd += abs_int(p - dc);
            end
        end
        sad = 1 << 30;
        if (top_av) begin
            mode = 0;
            sad = sv;
        end
        if (left_av && sh < sad) begin
            mode = 1;
            sad = sh;
        end
        if (sd < sad) begin
            mode = 2;
            sad = sd;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic take_result(input int w, input int mx, input int my, input int stall);
        int          exp_mode;
        int          exp_sad;
        int          n;
        logic [31:0] first_sad;
        expect_mb(w, mx, my, exp_mode, exp_sad);
        n = 0;
        while (res_valid_o !== 1'b1 && n < TIMEOUT_CYC) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (res_valid_o !== 1'b1) begin
            $display("Timeout: no result for macroblock (%0d,%0d) in %0d cycles", mx, my, n);
            timed_out = 1'b1;
            return;
        end
        first_sad = res_sad_o;
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        check_value("res_valid_o while stalled", res_valid_o, 1);
        check_value("busy_o with a result", busy_o, 1);
        check_value("res_mb_x_o", res_mb_x_o, mx);
        check_value("res_mb_y_o", res_mb_y_o, my);
        check_value("res_mode_o", res_mode_o, exp_mode);
        check_value("res_sad_o", res_sad_o, exp_sad);
        check_value("res_sad_o held", res_sad_o, first_sad);
        res_ready_i = 1'b1;
        @(posedge clk);
        #2;
        res_ready_i = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_o !== 1'b1 && res_valid_o !== 1'b1 && n < TIMEOUT_CYC) begin
            @(posedge clk);
            #2;
            n++;
        end
        check_value("res_valid_o after last macroblock", res_valid_o, 0);
        if (done_o !== 1'b1) begin
            $display("Timeout: done_o did not pulse after the last result");
            timed_out = 1'b1;
            return;
        end
        check_value("busy_o with done_o", busy_o, 0);
        @(posedge clk);
        #2;
        check_value("done_o one cycle wide", done_o, 0);
    endtask

    initial begin
        int seed_val;
        int row_err;
        rst = 1'b1;
        start_i = 1'b0;
        res_ready_i = 1'b0;
        frame_width_i = '0;
        frame_height_i = '0;
        checks = 0;
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        seed_val = $urandom(32'h3fac);
        frames[0] = '{1, 16, 16, PAT_FLAT, 0};
        frames[1] = '{2, 32, 32, PAT_VSTRIPE, 0};
        frames[2] = '{3, 48, 32, PAT_HSTRIPE, 0};
        frames[3] = '{3, 32, 32, PAT_FLAT, 0};     // All modes tie past the first MB
        frames[4] = '{4, 64, 48, PAT_RANDOM, 0};
        frames[5] = '{5, 32, 32, PAT_RANDOM, 5};
        frames[6] = '{6, 48, 16, PAT_RANDOM, 1};
        frames[7] = '{6, 16, 32, PAT_VSTRIPE, 0};  // Starts right after the previous done
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < N_ROWS && !timed_out; r++) begin
            row_err = errors;
            fill_frame(frames[r].pattern, frames[r].width, frames[r].height);
            frame_width_i = DIM_W'(frames[r].width);
            frame_height_i = DIM_W'(frames[r].height);
            start_i = 1'b1;
            @(posedge clk);
            #2;
            start_i = 1'b0;
            for (int my = 0; my < frames[r].height / MB_SIZE; my++) begin
                for (int mx = 0; mx < frames[r].width / MB_SIZE; mx++) begin
                    if (!timed_out)
                        take_result(frames[r].width, mx, my, frames[r].stall);
                end
            end
            if (!timed_out)
                wait_done();
            tests++;
            $display("test %0d, %s %0dx%0d, stall %0d: %0d errors%s", frames[r].test_no,
                     pattern_name(frames[r].pattern), frames[r].width, frames[r].height,
                     frames[r].stall, errors - row_err, timed_out ? ", timed out" : "");
        end
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, dut.u_asserts.assert_fails);
        if (errors == 0 && !timed_out && dut.u_asserts.assert_fails == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_h264_intra

//--- verilog.f
hdl/epu_geom_pkg.sv
hdl/intra_pkg.sv
hdl/luma_word_if.sv
hdl/epu_ctrl.sv
hdl/wb_frame_reader.sv
hdl/luma_fetch.sv
hdl/neighbor_store.sv
hdl/intra16_decide.sv
hdl/h264_intra_top.sv
test/h264_intra_asserts.sv
test/tb_h264_intra.sv
